//--- hw/pbus_pkg.sv
////////////////////
// single clock register bus, 32-bit words, 12-bit byte address
// region in addr[11:8], word offset in addr[3:2], other bits ignored
////////////////////

package pbus_pkg;

    localparam int unsigned PBUS_DATA_W   = 32;   // register word
    localparam int unsigned PBUS_ADDR_W   = 12;   // byte address
    localparam int unsigned PBUS_REGION_W = 4;    // region field width
    localparam int unsigned PBUS_OFFSET_W = 2;    // word offset width

    typedef logic [PBUS_DATA_W-1:0] pbus_data_t;
    typedef logic [PBUS_ADDR_W-1:0] pbus_addr_t;

    localparam int unsigned PBUS_REGION_LSB = 8;  // addr[11:8]
    localparam int unsigned PBUS_OFFSET_LSB = 2;  // addr[3:2]

    ////////////////////
    // address map
    localparam logic [PBUS_REGION_W-1:0] PBUS_TIM0_REGION = 4'd0;
    localparam logic [PBUS_REGION_W-1:0] PBUS_TIM1_REGION = 4'd1;
    localparam logic [PBUS_REGION_W-1:0] PBUS_GPIO_REGION = 4'd2;   // rest unmapped

    // timer words
    localparam logic [PBUS_OFFSET_W-1:0] TIM_CTRL_OFS   = 2'd0;
    localparam logic [PBUS_OFFSET_W-1:0] TIM_LOAD_OFS   = 2'd1;
    localparam logic [PBUS_OFFSET_W-1:0] TIM_COUNT_OFS  = 2'd2;    // read only
    localparam logic [PBUS_OFFSET_W-1:0] TIM_STATUS_OFS = 2'd3;    // w1c
    localparam int unsigned TIM_CTRL_EN_BIT  = 0;   // count enable
    localparam int unsigned TIM_CTRL_ARL_BIT = 1;   // auto-reload
    localparam int unsigned TIM_CTRL_IE_BIT  = 2;   // irq enable
    localparam int unsigned TIM_STAT_EXP_BIT = 0;   // expired flag

    // gpio words
    localparam logic [PBUS_OFFSET_W-1:0] GPIO_OUT_OFS      = 2'd0;
    localparam logic [PBUS_OFFSET_W-1:0] GPIO_IN_OFS       = 2'd1;  // read only
    localparam logic [PBUS_OFFSET_W-1:0] GPIO_IRQ_EN_OFS   = 2'd2;
    localparam logic [PBUS_OFFSET_W-1:0] GPIO_IRQ_STAT_OFS = 2'd3;  // w1c

    ////////////////////
    // interrupt vector
    localparam int unsigned PBUS_TIM0_IRQ   = 0;
    localparam int unsigned PBUS_TIM1_IRQ   = 1;
    localparam int unsigned PBUS_GPIOIN_IRQ = 2;
    localparam int unsigned PBUS_NUM_IRQ    = 3;

endpackage : pbus_pkg

//--- hw/pbus_timer.sv
////////////////////
// down counter, expiry set has priority over a same-cycle w1c of STATUS
////////////////////

`timescale 1ns/1ps

module pbus_timer import pbus_pkg::*; #(
    parameter logic [PBUS_REGION_W-1:0] REGION = PBUS_TIM0_REGION
) (
    input  logic       pbus_clock_i,
    input  logic       rst_i,
    input  logic       wr_en_i,
    input  logic       rd_en_i,
    input  pbus_addr_t addr_i,
    input  pbus_data_t wdata_i,
    output pbus_data_t rd_data_o,
    output logic       irq_o
);

    logic [PBUS_OFFSET_W-1:0] offset;
    logic                     sel;
    logic                     en_q, arl_q, ie_q, expired_q;
    pbus_data_t               load_q, count_q;
    logic                     tick, expire;
    logic                     wr_ctrl, wr_load, wr_stat;
    pbus_data_t               rd_word;

    ////////////////////
    // decode
    assign sel     = (addr_i[PBUS_REGION_LSB +: PBUS_REGION_W] == REGION);   // own region only
    assign offset  = addr_i[PBUS_OFFSET_LSB +: PBUS_OFFSET_W];
    assign wr_ctrl = wr_en_i & sel & (offset == TIM_CTRL_OFS);
    assign wr_load = wr_en_i & sel & (offset == TIM_LOAD_OFS);
    assign wr_stat = wr_en_i & sel & (offset == TIM_STATUS_OFS);

    assign tick    = en_q & (count_q != '0);   // still counting
    assign expire  = en_q & (count_q == '0);   // reached zero last edge

    ////////////////////
    // registers
    always_ff @(posedge pbus_clock_i) begin
        if (rst_i) begin
            en_q      <= 1'b0;
            arl_q     <= 1'b0;
            ie_q      <= 1'b0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
        end else begin
            if (wr_ctrl) begin                          // host write beats stop on expiry
                en_q  <= wdata_i[TIM_CTRL_EN_BIT];
                arl_q <= wdata_i[TIM_CTRL_ARL_BIT];
                ie_q  <= wdata_i[TIM_CTRL_IE_BIT];
            end else if (expire && !arl_q) begin
                en_q  <= 1'b0;                          // one shot done
            end
            if (wr_load) begin
                load_q <= wdata_i;
            end
            if (wr_load) begin
                count_q <= wdata_i;                     // LOAD also loads COUNT
            end else if (tick) begin
                count_q <= count_q - 1'b1;
            end else if (expire && arl_q) begin
                count_q <= load_q;                      // periodic reload
            end
            expired_q <= expire | (expired_q & ~(wr_stat & wdata_i[TIM_STAT_EXP_BIT]));
        end
    end

    // read mux, reserved bits zero
    always_comb begin
        rd_word = '0;
        case (offset)
            TIM_CTRL_OFS: begin
                rd_word[TIM_CTRL_EN_BIT]  = en_q;
                rd_word[TIM_CTRL_ARL_BIT] = arl_q;
                rd_word[TIM_CTRL_IE_BIT]  = ie_q;
            end
            TIM_LOAD_OFS:   rd_word = load_q;
            TIM_COUNT_OFS:  rd_word = count_q;
            TIM_STATUS_OFS: rd_word[TIM_STAT_EXP_BIT] = expired_q;
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge pbus_clock_i) begin
        if (rst_i) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= (rd_en_i && sel) ? rd_word : '0;   // zero when not addressed
        end
    end

    assign irq_o = expired_q & ie_q;   // level irq

endmodule : pbus_timer

//--- hw/pbus_gpio.sv
////////////////////
// inputs see two sync flops, so IN and change flags lag the pins by 2-3 cycles
////////////////////

`timescale 1ns/1ps

module pbus_gpio import pbus_pkg::*; #(
    parameter int unsigned GPIO_IN_WIDTH  = 8,   // up to 32
    parameter int unsigned GPIO_OUT_WIDTH = 8    // up to 32
) (
    input  logic                      pbus_clock_i,
    input  logic                      rst_i,
    input  logic                      wr_en_i,
    input  logic                      rd_en_i,
    input  pbus_addr_t                addr_i,
    input  pbus_data_t                wdata_i,
    input  logic [GPIO_IN_WIDTH-1:0]  gpio_in_i,
    output pbus_data_t                rd_data_o,
    output logic [GPIO_OUT_WIDTH-1:0] gpio_out_o,
    output logic                      irq_o
);

    logic [PBUS_OFFSET_W-1:0]  offset;
    logic                      sel;
    logic                      wr_out, wr_en, wr_stat;
    logic [GPIO_OUT_WIDTH-1:0] out_q;
    logic [GPIO_IN_WIDTH-1:0]  sync1_q, sync2_q, prev_q;
    logic [GPIO_IN_WIDTH-1:0]  irq_en_q, irq_stat_q;
    logic [GPIO_IN_WIDTH-1:0]  change;
    pbus_data_t                rd_word;

    assign sel     = (addr_i[PBUS_REGION_LSB +: PBUS_REGION_W] == PBUS_GPIO_REGION);
    assign offset  = addr_i[PBUS_OFFSET_LSB +: PBUS_OFFSET_W];
    assign wr_out  = wr_en_i & sel & (offset == GPIO_OUT_OFS);
    assign wr_en   = wr_en_i & sel & (offset == GPIO_IRQ_EN_OFS);
    assign wr_stat = wr_en_i & sel & (offset == GPIO_IRQ_STAT_OFS);

    assign change  = sync2_q ^ prev_q;   // edge on either polarity

    ////////////////////
    // registers
    always_ff @(posedge pbus_clock_i) begin
        if (rst_i) begin
            out_q      <= '0;
            sync1_q    <= '0;
            sync2_q    <= '0;
            prev_q     <= '0;
            irq_en_q   <= '0;
            irq_stat_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;           // first sync stage
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;             // last sampled value
            if (wr_out) out_q <= wdata_i[GPIO_OUT_WIDTH-1:0];
            if (wr_en)  irq_en_q <= wdata_i[GPIO_IN_WIDTH-1:0];
            // new change wins over clear, set regardless of enable
            irq_stat_q <= change |
                (irq_stat_q & ~({GPIO_IN_WIDTH{wr_stat}} & wdata_i[GPIO_IN_WIDTH-1:0]));
        end
    end

    always_comb begin
        case (offset)
            GPIO_OUT_OFS:      rd_word = pbus_data_t'(out_q);     // zero extended
            GPIO_IN_OFS:       rd_word = pbus_data_t'(sync2_q);
            GPIO_IRQ_EN_OFS:   rd_word = pbus_data_t'(irq_en_q);
            GPIO_IRQ_STAT_OFS: rd_word = pbus_data_t'(irq_stat_q);
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge pbus_clock_i) begin
        if (rst_i) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= (rd_en_i && sel) ? rd_word : '0;
        end
    end

    assign gpio_out_o = out_q;
    assign irq_o      = |(irq_stat_q & irq_en_q);   // any enabled flag

endmodule : pbus_gpio

//--- hw/pbus_resp_merge.sv
////////////////////
// peripherals hold rd_data at zero unless read, so a plain OR merges them
////////////////////

`timescale 1ns/1ps

module pbus_resp_merge import pbus_pkg::*; (
    input  logic                    pbus_clock_i,
    input  logic                    rst_i,
    input  logic                    rd_en_i,
    input  pbus_data_t              tim0_rd_data_i,
    input  pbus_data_t              tim1_rd_data_i,
    input  pbus_data_t              gpio_rd_data_i,
    input  logic                    tim0_irq_i,
    input  logic                    tim1_irq_i,
    input  logic                    gpio_irq_i,
    output pbus_data_t              rdata_o,
    output logic                    rvalid_o,
    output logic [PBUS_NUM_IRQ-1:0] int_o
);

    logic [PBUS_NUM_IRQ-1:0] irq_vec;

    always_comb begin
        irq_vec                  = '0;
        irq_vec[PBUS_TIM0_IRQ]   = tim0_irq_i;
        irq_vec[PBUS_TIM1_IRQ]   = tim1_irq_i;
        irq_vec[PBUS_GPIOIN_IRQ] = gpio_irq_i;
    end

    always_ff @(posedge pbus_clock_i) begin
        if (rst_i) begin
            rvalid_o <= 1'b0;
            int_o    <= '0;
        end else begin
            rvalid_o <= rd_en_i;    // fixed one cycle latency
            int_o    <= irq_vec;    // one cycle behind sources
        end
    end

    // unmapped reads fall out as zero
    assign rdata_o = tim0_rd_data_i | tim1_rd_data_i | gpio_rd_data_i;

endmodule : pbus_resp_merge

//--- hw/peripheral_bus.sv
////////////////////
// no back-pressure, host must never raise wr_en_i and rd_en_i together
////////////////////

`timescale 1ns/1ps

module peripheral_bus import pbus_pkg::*; #(
    parameter int unsigned GPIO_IN_WIDTH  = 8,
    parameter int unsigned GPIO_OUT_WIDTH = 8
) (
    input  logic                      pbus_clock_i,
    input  logic                      rst_i,
    input  logic                      wr_en_i,
    input  logic                      rd_en_i,
    input  pbus_addr_t                addr_i,
    input  pbus_data_t                wdata_i,
    input  logic [GPIO_IN_WIDTH-1:0]  gpio_in_i,
    output pbus_data_t                rdata_o,
    output logic                      rvalid_o,
    output logic [PBUS_NUM_IRQ-1:0]   int_o,
    output logic [GPIO_OUT_WIDTH-1:0] gpio_out_o
);

    pbus_data_t tim0_rd_data, tim1_rd_data, gpio_rd_data;   // registered, zero unless read
    logic       tim0_irq, tim1_irq, gpio_irq;

    ////////////////////
    // peripherals
    pbus_timer #(
        .REGION ( PBUS_TIM0_REGION )
    ) i_tim0 (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_i        ( rst_i        ),
        .wr_en_i      ( wr_en_i      ),
        .rd_en_i      ( rd_en_i      ),
        .addr_i       ( addr_i       ),
        .wdata_i      ( wdata_i      ),
        .rd_data_o    ( tim0_rd_data ),
        .irq_o        ( tim0_irq     )
    );

    pbus_timer #(
        .REGION ( PBUS_TIM1_REGION )
    ) i_tim1 (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_i        ( rst_i        ),
        .wr_en_i      ( wr_en_i      ),
        .rd_en_i      ( rd_en_i      ),
        .addr_i       ( addr_i       ),
        .wdata_i      ( wdata_i      ),
        .rd_data_o    ( tim1_rd_data ),
        .irq_o        ( tim1_irq     )
    );

    pbus_gpio #(
        .GPIO_IN_WIDTH  ( GPIO_IN_WIDTH  ),
        .GPIO_OUT_WIDTH ( GPIO_OUT_WIDTH )
    ) i_gpio (
        .pbus_clock_i ( pbus_clock_i ),
        .rst_i        ( rst_i        ),
        .wr_en_i      ( wr_en_i      ),
        .rd_en_i      ( rd_en_i      ),
        .addr_i       ( addr_i       ),
        .wdata_i      ( wdata_i      ),
        .gpio_in_i    ( gpio_in_i    ),
        .rd_data_o    ( gpio_rd_data ),
        .gpio_out_o   ( gpio_out_o   ),
        .irq_o        ( gpio_irq     )
    );

    ////////////////////
    // response and irq merge
    pbus_resp_merge i_merge (
        .pbus_clock_i   ( pbus_clock_i ),
        .rst_i          ( rst_i        ),
        .rd_en_i        ( rd_en_i      ),
        .tim0_rd_data_i ( tim0_rd_data ),
        .tim1_rd_data_i ( tim1_rd_data ),
        .gpio_rd_data_i ( gpio_rd_data ),
        .tim0_irq_i     ( tim0_irq     ),
        .tim1_irq_i     ( tim1_irq     ),
        .gpio_irq_i     ( gpio_irq     ),
        .rdata_o        ( rdata_o      ),
        .rvalid_o       ( rvalid_o     ),
        .int_o          ( int_o        )
    );

endmodule : peripheral_bus

//--- sim/pbus_resp_merge_chk.sv
////////////////////
// bound into every pbus_resp_merge, latency and idle checks held off in reset
////////////////////

`timescale 1ns/1ps

module pbus_resp_merge_chk import pbus_pkg::*; (
    input logic                    pbus_clock_i,
    input logic                    rst_i,
    input logic                    rd_en_i,
    input pbus_data_t              rdata_o,
    input logic                    rvalid_o,
    input logic [PBUS_NUM_IRQ-1:0] int_o
);

    // one cycle read latency
    a_rvalid_lat: assert property (@(posedge pbus_clock_i) disable iff (rst_i)
        !$past(rst_i) |-> (rvalid_o == $past(rd_en_i)))
        else $error("rvalid_o does not follow rd_en_i by one cycle");

    a_rdata_idle: assert property (@(posedge pbus_clock_i) disable iff (rst_i)
        !rvalid_o |-> (rdata_o == '0))
        else $error("rdata_o nonzero while rvalid_o low");

    a_int_reset: assert property (@(posedge pbus_clock_i)
        $fell(rst_i) |-> (int_o == '0))
        else $error("int_o nonzero after reset");

endmodule : pbus_resp_merge_chk

bind pbus_resp_merge pbus_resp_merge_chk i_chk (
    .pbus_clock_i ( pbus_clock_i ),
    .rst_i        ( rst_i        ),
    .rd_en_i      ( rd_en_i      ),
    .rdata_o      ( rdata_o      ),
    .rvalid_o     ( rvalid_o     ),
    .int_o        ( int_o        )
);

//--- sim/tb_peripheral_bus.sv
////////////////////
// random register traffic against a cycle model, default 8-bit gpio widths
////////////////////

`timescale 1ns/1ps

module tb_peripheral_bus import pbus_pkg::*;;

    localparam int unsigned GPIO_IN_W       = 8;
    localparam int unsigned GPIO_OUT_W      = 8;
    localparam int unsigned RESET_CYCLES    = 8;
    localparam int unsigned N_OPS           = 200;   // random ops in test 2
    localparam int unsigned WATCHDOG_CYCLES = N_OPS * 20 + RESET_CYCLES;
    localparam real         CLK_PERIOD      = 10.0;

    logic                    clk;
    logic                    rst;
    logic                    wr_en, rd_en;
    pbus_addr_t              addr;
    pbus_data_t              wdata;
    logic [GPIO_IN_W-1:0]    gpio_in;
    pbus_data_t              rdata_o;
    logic                    rvalid_o;
    logic [PBUS_NUM_IRQ-1:0] int_o;
    logic [GPIO_OUT_W-1:0]   gpio_out_o;

    logic [31:0] seed = 32'hb8fbdd0b;
    int          errors = 0;
    int          tests_failed = 0;
    int          test_num = 0;
    int          test_start_errs = 0;

    ////////////////////
    // model state
    logic       m_en[2], m_arl[2], m_ie[2], m_exp[2];
    pbus_data_t m_load[2], m_count[2];
    logic [GPIO_OUT_W-1:0]   m_out;
    logic [GPIO_IN_W-1:0]    m_sync1, m_sync2, m_prev, m_gen, m_gstat;
    logic                    m_rvalid;
    pbus_data_t              m_rdata;
    logic [PBUS_NUM_IRQ-1:0] m_int;

    peripheral_bus i_dut (
        .pbus_clock_i ( clk        ),
        .rst_i        ( rst        ),
        .wr_en_i      ( wr_en      ),
        .rd_en_i      ( rd_en      ),
        .addr_i       ( addr       ),
        .wdata_i      ( wdata      ),
        .gpio_in_i    ( gpio_in    ),
        .rdata_o      ( rdata_o    ),
        .rvalid_o     ( rvalid_o   ),
        .int_o        ( int_o      ),
        .gpio_out_o   ( gpio_out_o )
    );

    always #(CLK_PERIOD / 2.0) clk = ~clk;   // 10 ns period

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // region and offset placed, ignored bits filled with junk
    function automatic pbus_addr_t reg_addr(input logic [3:0] region, input logic [1:0] ofs,
                                            input logic [31:0] junk);
        pbus_addr_t a;
        a = pbus_addr_t'(junk);
        a[PBUS_REGION_LSB +: PBUS_REGION_W] = region;
        a[PBUS_OFFSET_LSB +: PBUS_OFFSET_W] = ofs;
        return a;
    endfunction

    ////////////////////
    // compare tasks
    task automatic check_data(input pbus_data_t got, input pbus_data_t exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @%0t: %s got %h exp %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_irq(input logic [PBUS_NUM_IRQ-1:0] got,
                             input logic [PBUS_NUM_IRQ-1:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @%0t: %s got %b exp %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_gpio(input logic [GPIO_OUT_W-1:0] got,
                              input logic [GPIO_OUT_W-1:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @%0t: %s got %h exp %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @%0t: %s got %b exp %b", $time, msg, got, exp);
        end
    endtask

    ////////////////////
    // register model
    function automatic pbus_data_t model_read(input pbus_addr_t a);
        logic [3:0] region;
        logic [1:0] ofs;
        int         t;
        pbus_data_t v;
        region = a[PBUS_REGION_LSB +: PBUS_REGION_W];
        ofs    = a[PBUS_OFFSET_LSB +: PBUS_OFFSET_W];
        v      = '0;
        t      = (region == PBUS_TIM1_REGION) ? 1 : 0;
        if (region == PBUS_TIM0_REGION || region == PBUS_TIM1_REGION) begin
            case (ofs)
                TIM_CTRL_OFS:   v = pbus_data_t'({m_ie[t], m_arl[t], m_en[t]});
                TIM_LOAD_OFS:   v = m_load[t];
                TIM_COUNT_OFS:  v = m_count[t];
                default:        v = pbus_data_t'(m_exp[t]);
            endcase
        end else if (region == PBUS_GPIO_REGION) begin
            case (ofs)
                GPIO_OUT_OFS:    v = pbus_data_t'(m_out);
                GPIO_IN_OFS:     v = pbus_data_t'(m_sync2);
                GPIO_IRQ_EN_OFS: v = pbus_data_t'(m_gen);
                default:         v = pbus_data_t'(m_gstat);
            endcase
        end
        return v;                                     // unmapped stays zero
    endfunction

    task automatic model_reset();
        for (int t = 0; t < 2; t++) begin
            m_en[t]    = 0;
            m_arl[t]   = 0;
            m_ie[t]    = 0;
            m_exp[t]   = 0;
            m_load[t]  = '0;
            m_count[t] = '0;
        end
        m_out    = '0;
        m_sync1  = '0;
        m_sync2  = '0;
        m_prev   = '0;
        m_gen    = '0;
        m_gstat  = '0;
        m_rvalid = 0;
        m_rdata  = '0;
        m_int    = '0;
    endtask

    // one clock edge of the model, inputs as seen at the edge
    task automatic model_tick();
        logic [3:0] region;
        logic [1:0] ofs;
        logic       sel, expire, tick, clr;
        logic [GPIO_IN_W-1:0] change;
        region   = addr[PBUS_REGION_LSB +: PBUS_REGION_W];
        ofs      = addr[PBUS_OFFSET_LSB +: PBUS_OFFSET_W];
        m_rvalid = rd_en;
        m_rdata  = rd_en ? model_read(addr) : '0;
        m_int[PBUS_TIM0_IRQ]   = m_exp[0] & m_ie[0];   // sources before the edge
        m_int[PBUS_TIM1_IRQ]   = m_exp[1] & m_ie[1];
        m_int[PBUS_GPIOIN_IRQ] = |(m_gstat & m_gen);
        for (int t = 0; t < 2; t++) begin
            sel    = wr_en && (region == ((t == 0) ? PBUS_TIM0_REGION : PBUS_TIM1_REGION));
            expire = m_en[t] && (m_count[t] == '0);
            tick   = m_en[t] && (m_count[t] != '0);
            clr    = sel && (ofs == TIM_STATUS_OFS) && wdata[TIM_STAT_EXP_BIT];
            if (sel && ofs == TIM_LOAD_OFS) begin
                m_count[t] = wdata;
            end else if (tick) begin
                m_count[t] = m_count[t] - 1;
            end else if (expire && m_arl[t]) begin
                m_count[t] = m_load[t];               // reload uses old LOAD
            end
            if (sel && ofs == TIM_LOAD_OFS) m_load[t] = wdata;
            if (sel && ofs == TIM_CTRL_OFS) begin
                m_en[t]  = wdata[TIM_CTRL_EN_BIT];
                m_arl[t] = wdata[TIM_CTRL_ARL_BIT];
                m_ie[t]  = wdata[TIM_CTRL_IE_BIT];
            end else if (expire && !m_arl[t]) begin
                m_en[t] = 0;
            end
            m_exp[t] = expire | (m_exp[t] & ~clr);
        end
        sel    = wr_en && (region == PBUS_GPIO_REGION);
        change = m_sync2 ^ m_prev;
        m_gstat = change | (m_gstat & ~((sel && ofs == GPIO_IRQ_STAT_OFS) ?
                                         wdata[GPIO_IN_W-1:0] : '0));
        m_prev  = m_sync2;
        m_sync2 = m_sync1;
        m_sync1 = gpio_in;
        if (sel && ofs == GPIO_OUT_OFS)    m_out = wdata[GPIO_OUT_W-1:0];
        if (sel && ofs == GPIO_IRQ_EN_OFS) m_gen = wdata[GPIO_IN_W-1:0];
    endtask

    ////////////////////
    // bus cycles, called at a falling edge
    task automatic step(input logic wr, input logic rd, input pbus_addr_t a, input pbus_data_t d);
        wr_en = wr;
        rd_en = rd;
        addr  = a;
        wdata = d;
        @(posedge clk);
        model_tick();
        @(negedge clk);
        check_bit(rvalid_o, m_rvalid, "rvalid_o");   // outputs settled by now
        check_data(rdata_o, m_rdata, "rdata_o");
        check_irq(int_o, m_int, "int_o");
        check_gpio(gpio_out_o, m_out, "gpio_out_o");
        wr_en = 0;
        rd_en = 0;
    endtask

    task automatic idle(input int n);
        repeat (n) step(0, 0, '0, '0);
    endtask

    task automatic write_reg(input pbus_addr_t a, input pbus_data_t d);
        step(1, 0, a, d);
    endtask

    task automatic expect_read(input pbus_addr_t a, input pbus_data_t exp, input string msg);
        step(0, 1, a, '0);
        check_bit(rvalid_o, 1'b1, {msg, " rvalid"});
        check_data(rdata_o, exp, msg);
    endtask

    task automatic begin_test();
        test_num++;
        test_start_errs = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errs) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, errors - test_start_errs);
        end
    endtask

    ////////////////////
    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [3:0]  region;
        logic [1:0]  ofs;
        int          n;
        logic [GPIO_IN_W-1:0] pat, last_pat, en_mask, stat_exp, clr;
        clk     = 0;
        rst     = 1;
        wr_en   = 0;
        rd_en   = 0;
        addr    = '0;
        wdata   = '0;
        gpio_in = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 0;

        begin_test();                                  // reset values
        check_bit(rvalid_o, 1'b0, "rvalid after reset");
        check_irq(int_o, '0, "int after reset");
        check_gpio(gpio_out_o, '0, "gpio_out after reset");
        for (int rg = 0; rg < 3; rg++) begin
            for (int o = 0; o < 4; o++) begin
                expect_read(reg_addr(4'(rg), 2'(o), rand_next()), '0, "reset read");
            end
        end
        end_test("reset");

        begin_test();                                  // random traffic
        for (int i = 0; i < N_OPS; i++) begin
            r = rand_next();
            case (r[2:0] % 3'd7)
                0: {region, ofs} = {PBUS_GPIO_REGION, GPIO_OUT_OFS};
                1: {region, ofs} = {PBUS_GPIO_REGION, GPIO_IRQ_EN_OFS};
                2: {region, ofs} = {PBUS_TIM0_REGION, TIM_LOAD_OFS};
                3: {region, ofs} = {PBUS_TIM1_REGION, TIM_LOAD_OFS};
                4: {region, ofs} = {PBUS_TIM0_REGION, TIM_CTRL_OFS};
                5: {region, ofs} = {PBUS_TIM1_REGION, TIM_CTRL_OFS};
                default: {region, ofs} = {4'(3 + r[7:4] % 13), r[9:8]};   // unmapped
            endcase
            if (r[3]) begin
                write_reg(reg_addr(region, ofs, r), rand_next());
            end else if (region > PBUS_GPIO_REGION) begin
                expect_read(reg_addr(region, ofs, r), '0, "unmapped read");
            end else begin
                step(0, 1, reg_addr(region, ofs, r), '0);   // value checked against model
            end
        end
        write_reg(reg_addr(PBUS_TIM0_REGION, TIM_CTRL_OFS, 0), '0);
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_CTRL_OFS, 0), '0);
        write_reg(reg_addr(PBUS_TIM0_REGION, TIM_STATUS_OFS, 0), 32'h1);
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_STATUS_OFS, 0), 32'h1);
        write_reg(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_EN_OFS, 0), '0);
        idle(2);
        end_test("random access");

        begin_test();                                  // one shot on tim0
        n = 5 + rand_next() % 16;
        write_reg(reg_addr(PBUS_TIM0_REGION, TIM_LOAD_OFS, 0), n);
        write_reg(reg_addr(PBUS_TIM0_REGION, TIM_CTRL_OFS, 0), 32'h5);   // en + irq en
        idle(n + 3);
        check_irq(int_o, 3'b001, "tim0 irq");
        expect_read(reg_addr(PBUS_TIM0_REGION, TIM_STATUS_OFS, 0), 32'h1, "tim0 expired");
        expect_read(reg_addr(PBUS_TIM0_REGION, TIM_CTRL_OFS, 0), 32'h4, "tim0 ctrl");
        expect_read(reg_addr(PBUS_TIM0_REGION, TIM_COUNT_OFS, 0), '0, "tim0 count");
        write_reg(reg_addr(PBUS_TIM0_REGION, TIM_STATUS_OFS, 0), 32'h1);
        idle(2);
        expect_read(reg_addr(PBUS_TIM0_REGION, TIM_STATUS_OFS, 0), '0, "tim0 cleared");
        check_irq(int_o, '0, "tim0 irq cleared");
        end_test("timer one shot");

        begin_test();                                  // auto-reload on tim1
        n = 8 + rand_next() % 8;
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_LOAD_OFS, 0), n);
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_CTRL_OFS, 0), 32'h7);
        idle(n + 3);
        check_irq(int_o, 3'b010, "only tim1 irq");
        expect_read(reg_addr(PBUS_TIM1_REGION, TIM_STATUS_OFS, 0), 32'h1, "tim1 expired");
        step(0, 1, reg_addr(PBUS_TIM1_REGION, TIM_COUNT_OFS, 0), '0);
        check_bit(rdata_o != '0, 1'b1, "tim1 count reloaded");
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_CTRL_OFS, 0), '0);
        write_reg(reg_addr(PBUS_TIM1_REGION, TIM_STATUS_OFS, 0), 32'h1);
        idle(2);
        check_irq(int_o, '0, "tim1 irq cleared");
        end_test("timer auto reload");

        begin_test();                                  // gpio change detect
        en_mask = GPIO_IN_W'(rand_next());
        write_reg(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_EN_OFS, 0), pbus_data_t'(en_mask));
        write_reg(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_STAT_OFS, 0), 32'hff);
        stat_exp = '0;
        last_pat = gpio_in;
        for (int i = 0; i < 20; i++) begin
            pat     = GPIO_IN_W'(rand_next());
            gpio_in = pat;
            idle(4);                                   // through sync and edge detect
            stat_exp = stat_exp | (pat ^ last_pat);
            last_pat = pat;
            expect_read(reg_addr(PBUS_GPIO_REGION, GPIO_IN_OFS, 0), pbus_data_t'(pat),
                        "gpio in");
            expect_read(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_STAT_OFS, 0),
                        pbus_data_t'(stat_exp), "gpio stat");
            check_bit(int_o[PBUS_GPIOIN_IRQ], |(stat_exp & en_mask), "gpio irq");
            clr = GPIO_IN_W'(rand_next());
            write_reg(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_STAT_OFS, 0), pbus_data_t'(clr));
            stat_exp = stat_exp & ~clr;
            expect_read(reg_addr(PBUS_GPIO_REGION, GPIO_IRQ_STAT_OFS, 0),
                        pbus_data_t'(stat_exp), "gpio w1c");
        end
        end_test("gpio input irq");

        $display("summary: %0d tests, %0d failed, %0d check errors", test_num, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_peripheral_bus

//--- sources.f
hw/pbus_pkg.sv
hw/pbus_timer.sv
hw/pbus_gpio.sv
hw/pbus_resp_merge.sv
hw/peripheral_bus.sv
sim/pbus_resp_merge_chk.sv
sim/tb_peripheral_bus.sv

//--- run_sim.sh
#!/bin/sh
# build and run the peripheral bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_peripheral_bus \
    -Mdir obj_dir \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_peripheral_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
